//--- logic/history_buffer.sv
`timescale 1ns/100ps
`default_nettype none
`include "lz_consts.svh"

// byte history with one write port and one registered read port
module history_buffer (
	input  wire logic clock,
	input  wire lz_history_pkg::history_addr_t rd_addr,
	input  wire lz_history_pkg::history_addr_t wr_addr,
	input  wire logic wr_en,
	input  wire lz_history_pkg::byte_t wr_byte,
	output lz_history_pkg::byte_t rd_byte
);
	// all zero at start, so a copy reaching past the first byte reads zeros
	lz_history_pkg::byte_t mem [`LZ_HISTORY_DEPTH] = '{default: '0};

	logic collide;	// read and write hit the same byte this cycle

	assign collide = wr_en && (wr_addr == rd_addr);

	always_ff @(posedge clock) begin
		if (wr_en)
			mem[wr_addr] <= wr_byte;
	end

	// an offset-1 copy reads the byte being written in the same cycle
	always_ff @(posedge clock) begin
		if (collide)
			rd_byte <= wr_byte;	// new byte, not the stale one
		else
			rd_byte <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- logic/lz_consts.svh
`ifndef LZ_CONSTS_SVH
`define LZ_CONSTS_SVH

// bytes kept for copy tokens to reach back into
// the 12-bit offset field of a copy token limits this to 4096
`define LZ_HISTORY_DEPTH 4096

// token queue entries
// the upstream starts with exactly this many credits
`define LZ_TOKEN_QUEUE_DEPTH 4

// bytes the engine may emit before the sink returns any credit
`define LZ_OUT_CREDITS 2

`endif

//--- logic/lz_copy_engine.sv
`timescale 1ns/100ps
`default_nettype none
`include "lz_consts.svh"

module lz_copy_engine (
	input  wire logic clock,
	input  wire logic reset,
	token_link_if.engine link,
	input  wire logic out_credit,
	output lz_history_pkg::byte_t out_byte,
	output logic out_valid,
	output lz_history_pkg::history_addr_t rd_addr,
	output lz_history_pkg::history_addr_t wr_addr,
	output logic wr_en,
	output lz_history_pkg::byte_t wr_byte,
	input  wire lz_history_pkg::byte_t rd_byte
);
	lz_token_pkg::engine_state_t state;
	lz_token_pkg::copy_length_t token_length;
	lz_token_pkg::copy_offset_t token_offset;
	lz_token_pkg::copy_length_t remaining;	// bytes left after the current one
	lz_history_pkg::history_addr_t wr_ptr;	// next byte of output history
	lz_history_pkg::history_addr_t rd_ptr;	// address of the byte now on rd_byte
	lz_history_pkg::byte_t literal_byte;
	lz_history_pkg::credit_count_t credit_cnt;	// output credits held
	logic take;

	assign {token_length, token_offset} = link.data;

	assign take = (state == lz_token_pkg::st_idle) && link.valid;
	assign link.take = take;

	// a byte goes out whenever one is pending and a credit is held
	assign out_valid = (state != lz_token_pkg::st_idle) && (credit_cnt != '0);
	assign out_byte = (state == lz_token_pkg::st_literal) ? literal_byte : rd_byte;

	// every emitted byte also lands in the history
	assign wr_en = out_valid;
	assign wr_byte = out_byte;
	assign wr_addr = wr_ptr;

	always_comb begin
		case (state)
			lz_token_pkg::st_idle: rd_addr = wr_ptr - token_offset;	// copy source on a take
			lz_token_pkg::st_copy: rd_addr = out_valid ? rd_ptr + 1'b1 : rd_ptr;
			default: rd_addr = rd_ptr;	// hold the read while stalled
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= lz_token_pkg::st_idle;
			wr_ptr <= '0;
			rd_ptr <= '0;
			remaining <= '0;
			credit_cnt <= lz_history_pkg::credit_count_t'(`LZ_OUT_CREDITS);
		end else begin
			rd_ptr <= rd_addr;
			if (out_valid)
				wr_ptr <= wr_ptr + 1'b1;

			// a credit back in the same cycle as a byte leaves the count alone
			if (out_valid && !out_credit)
				credit_cnt <= credit_cnt - 1'b1;
			else if (!out_valid && out_credit)
				credit_cnt <= credit_cnt + 1'b1;

			case (state)
				lz_token_pkg::st_idle: begin
					if (take) begin
						state <= link.is_copy ? lz_token_pkg::st_copy : lz_token_pkg::st_literal;
						remaining <= token_length;
					end
				end
				lz_token_pkg::st_literal: begin
					if (out_valid)
						state <= lz_token_pkg::st_idle;
				end
				lz_token_pkg::st_copy: begin
					if (out_valid) begin
						if (remaining == '0)
							state <= lz_token_pkg::st_idle;
						else
							remaining <= remaining - 1'b1;
					end
				end
				default: state <= lz_token_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (take)
			literal_byte <= link.data[7:0];
	end

	// the upstream compressor must never emit a copy from the current position
	assert property (@(posedge clock) disable iff (reset)
		take && link.is_copy |-> token_offset != '0)
		else $error("copy token with zero offset");

	// the sink returns at most one credit per byte it was sent
	assert property (@(posedge clock) disable iff (reset)
		credit_cnt <= lz_history_pkg::credit_count_t'(`LZ_OUT_CREDITS))
		else $error("output credits above the initial count");

endmodule

`default_nettype wire

//--- logic/lz_decompressor.sv
`timescale 1ns/100ps
`default_nettype none

module lz_decompressor (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic token_valid,	// only while the upstream holds a credit
	input  wire logic token_is_copy,
	input  wire lz_token_pkg::token_data_t token_data,
	input  wire logic out_credit,	// one pulse per byte the sink consumed
	output logic in_credit,
	output lz_history_pkg::byte_t out_byte,
	output logic out_valid
);
	lz_history_pkg::history_addr_t rd_addr;
	lz_history_pkg::history_addr_t wr_addr;
	logic wr_en;
	lz_history_pkg::byte_t wr_byte;
	lz_history_pkg::byte_t rd_byte;

	token_link_if link_i ();

	token_fifo fifo_i (
		.clock         (clock),
		.reset         (reset),
		.token_valid   (token_valid),
		.token_is_copy (token_is_copy),
		.token_data    (token_data),
		.in_credit     (in_credit),
		.link          (link_i.queue)
	);

	lz_copy_engine engine_i (
		.clock      (clock),
		.reset      (reset),
		.link       (link_i.engine),
		.out_credit (out_credit),
		.out_byte   (out_byte),
		.out_valid  (out_valid),
		.rd_addr    (rd_addr),
		.wr_addr    (wr_addr),
		.wr_en      (wr_en),
		.wr_byte    (wr_byte),
		.rd_byte    (rd_byte)
	);

	history_buffer history_i (
		.clock   (clock),
		.rd_addr (rd_addr),
		.wr_addr (wr_addr),
		.wr_en   (wr_en),
		.wr_byte (wr_byte),
		.rd_byte (rd_byte)
	);

endmodule

`default_nettype wire

//--- logic/lz_history_pkg.sv
`default_nettype none
`include "lz_consts.svh"

// storage side of the decompressor
package lz_history_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [$clog2(`LZ_HISTORY_DEPTH)-1:0] history_addr_t;

	// counts 0 up to the queue depth inclusive
	typedef logic [$clog2(`LZ_TOKEN_QUEUE_DEPTH+1)-1:0] credit_count_t;

endpackage

`default_nettype wire

//--- logic/lz_token_pkg.sv
`default_nettype none
`include "lz_consts.svh"

// token format as seen at the decompressor input
package lz_token_pkg;

	typedef logic [3:0] copy_length_t;	// bytes to copy minus one
	typedef logic [$clog2(`LZ_HISTORY_DEPTH)-1:0] copy_offset_t;	// distance back, never zero

	// a copy token packs length above offset; a literal uses the low byte
	typedef logic [$bits(copy_length_t)+$bits(copy_offset_t)-1:0] token_data_t;

	typedef enum logic [1:0] {
		st_idle,	// waiting for a token
		st_literal,	// one byte to emit
		st_copy		// streaming bytes back out of the history
	} engine_state_t;

endpackage

`default_nettype wire

//--- logic/token_fifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "lz_consts.svh"

module token_fifo (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic token_valid,
	input  wire logic token_is_copy,
	input  wire lz_token_pkg::token_data_t token_data,
	output logic in_credit,
	token_link_if.queue link
);
	localparam int ptr_width = $clog2(`LZ_TOKEN_QUEUE_DEPTH);

	typedef logic [ptr_width-1:0] slot_ptr_t;

	logic slot_is_copy [`LZ_TOKEN_QUEUE_DEPTH];
	lz_token_pkg::token_data_t slot_data [`LZ_TOKEN_QUEUE_DEPTH];
	slot_ptr_t wr_ptr;
	slot_ptr_t rd_ptr;
	lz_history_pkg::credit_count_t fill;	// tokens currently held
	logic full;
	logic push;
	logic pop;

	// wraps at the queue depth, which need not be a power of two
	function automatic slot_ptr_t next_ptr(input slot_ptr_t ptr);
		if (ptr == slot_ptr_t'(`LZ_TOKEN_QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full = fill == lz_history_pkg::credit_count_t'(`LZ_TOKEN_QUEUE_DEPTH);
	assign pop = link.valid && link.take;
	assign push = token_valid && (!full || pop);
	assign in_credit = pop;	// one credit back per token that leaves

	assign link.valid = fill != '0;
	assign link.is_copy = slot_is_copy[rd_ptr];
	assign link.data = slot_data[rd_ptr];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: ;	// both or neither
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			slot_is_copy[wr_ptr] <= token_is_copy;
			slot_data[wr_ptr] <= token_data;
		end
	end

	// upstream sends only against a credit, so a full queue takes a token
	// only when its head leaves in the same cycle
	assert property (@(posedge clock) disable iff (reset) token_valid |-> !full || pop)
		else $error("token arrived while queue full and no credit outstanding");

endmodule

`default_nettype wire

//--- logic/token_link_if.sv
`timescale 1ns/100ps
`default_nettype none

// hands the token at the queue head to the copy engine
// a transfer happens on a cycle with valid and take both high
interface token_link_if;

	logic valid;	// queue head holds a token
	logic is_copy;	// head token is a copy, else a literal
	lz_token_pkg::token_data_t data;
	logic take;	// engine accepts the head this cycle

	modport queue (
		output valid,
		output is_copy,
		output data,
		input  take
	);

	modport engine (
		input  valid,
		input  is_copy,
		input  data,
		output take
	);

endinterface

`default_nettype wire

//--- project.f
+incdir+logic
logic/lz_token_pkg.sv
logic/lz_history_pkg.sv
logic/token_link_if.sv
logic/token_fifo.sv
logic/history_buffer.sv
logic/lz_copy_engine.sv
logic/lz_decompressor.sv
test/lz_checker.sv
test/lz_decompressor_tb.sv

//--- run.sh
#!/bin/sh
# builds and runs the decompressor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module lz_decompressor_tb -o lz_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/lz_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^TB PASSED$"; then
	exit 0
fi
exit 1

//--- test/lz_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "lz_consts.svh"

// reference history that expands every accepted token into expected bytes
module lz_checker (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic token_valid,
	input  wire logic token_is_copy,
	input  wire lz_token_pkg::token_data_t token_data,
	input  wire logic in_credit,
	input  wire logic out_valid,
	input  wire lz_history_pkg::byte_t out_byte,
	input  wire logic test_end,	// held high until test_ack answers
	input  wire logic [3:0] test_id,
	output logic test_ack,
	output int error_count,
	output int checked_count
);
	localparam int stall_limit = 2000;	// cycles allowed for a test to drain

	// unwritten history reads as zero, same as the DUT memory
	lz_history_pkg::byte_t ref_hist [`LZ_HISTORY_DEPTH] = '{default: '0};
	lz_history_pkg::history_addr_t ref_wr = '0;
	lz_history_pkg::byte_t expected [$];
	int errors = 0;
	int checked = 0;
	int errors_at_start = 0;
	int checked_at_start = 0;
	int drain_cycles = 0;
	int tokens_seen = 0;	// tokens handed to the queue
	int credits_seen = 0;	// in_credit pulses matched to a token
	logic ack = 1'b0;

	assign test_ack = ack;
	assign error_count = errors;
	assign checked_count = checked;

	// bytes are produced one at a time so an overlapping copy sees its own output
	task automatic expand_token(input logic is_copy, input lz_token_pkg::token_data_t data);
		lz_token_pkg::copy_length_t length;
		lz_token_pkg::copy_offset_t offset;
		lz_history_pkg::byte_t next_byte;
		int count;
		{length, offset} = data;
		count = is_copy ? int'(length) + 1 : 1;
		for (int i = 0; i < count; i++) begin
			next_byte = is_copy ? ref_hist[ref_wr - offset] : data[7:0];
			expected.push_back(next_byte);
			ref_hist[ref_wr] = next_byte;
			ref_wr++;
		end
	endtask

	always @(posedge clock) begin
		lz_history_pkg::byte_t want;
		if (!reset) begin
			if (out_valid && expected.size() == 0) begin
				$display("byte %02h came out with no token left to account for it", out_byte);
				errors++;
			end else if (out_valid) begin
				want = expected.pop_front();
				checked++;
				if (out_byte !== want) begin
					$display("Fail out_byte expected %02h actual %02h", want, out_byte);
					errors++;
				end
			end

			// a credit only comes back for a token already sitting in the queue
			if (in_credit && credits_seen == tokens_seen) begin
				$display("in_credit returned with no token waiting in the queue");
				errors++;
			end else if (in_credit)
				credits_seen++;

			if (token_valid) begin
				expand_token(token_is_copy, token_data);	// same edge the queue pushes it
				tokens_seen++;
			end

			if (!test_end) begin
				ack <= 1'b0;
				drain_cycles = 0;
			end else if (!ack && expected.size() == 0) begin
				// every token has left the queue once its bytes are out
				if (credits_seen != tokens_seen) begin
					$display("Fail in_credit count expected %0h actual %0h",
						tokens_seen, credits_seen);
					errors++;
				end
				$display("test %0d %s, %0d bytes", test_id,
					(errors == errors_at_start) ? "ok" : "with errors", checked - checked_at_start);
				errors_at_start = errors;
				checked_at_start = checked;
				ack <= 1'b1;
			end else if (!ack && drain_cycles == stall_limit) begin
				$display("test %0d: output stalled with %0d bytes still owed", test_id,
					expected.size());
				errors++;
				expected.delete();
				errors_at_start = errors;
				checked_at_start = checked;
				ack <= 1'b1;
			end else if (!ack)
				drain_cycles++;
		end
	end

endmodule

`default_nettype wire

//--- test/lz_decompressor_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "lz_consts.svh"

module lz_decompressor_tb;
	typedef struct packed {
		logic [3:0] test;
		logic is_copy;
		lz_token_pkg::token_data_t data;	// copy is {length - 1, offset}
	} stim_t;

	localparam int stim_count = 12;
	localparam int credit_limit = 1000;
	localparam int drain_limit = 2500;	// beyond the checker's own stall limit

	stim_t stim_table [stim_count] = '{
		'{4'd1, 1'b0, 16'h0048},	// H at 0
		'{4'd1, 1'b0, 16'h0069},
		'{4'd1, 1'b0, 16'h0021},
		'{4'd2, 1'b1, 16'h1003},	// 2 bytes from 3 back
		'{4'd3, 1'b0, 16'h007a},	// z at 5
		'{4'd3, 1'b1, 16'hf001},	// z repeated 16 times
		'{4'd4, 1'b1, 16'h3013},	// reads bytes the engine copied
		'{4'd5, 1'b0, 16'h0071},
		'{4'd5, 1'b1, 16'h7002},
		'{4'd5, 1'b0, 16'h0072},
		'{4'd5, 1'b1, 16'hb021},
		'{4'd6, 1'b1, 16'h5fa0}	// lands on never written bytes
	};

	logic clock;
	logic reset;
	logic token_valid;
	logic token_is_copy;
	lz_token_pkg::token_data_t token_data;
	logic out_credit;
	logic in_credit;
	lz_history_pkg::byte_t out_byte;
	logic out_valid;
	logic test_end;
	logic [3:0] test_id;
	logic test_ack;
	int error_count;
	int checked_count;
	int tokens_sent = 0;
	int credits_back = 0;
	int bytes_consumed = 0;
	int credits_returned = 0;
	int seed = 32'h684;

	lz_decompressor dut_i (
		.clock         (clock),
		.reset         (reset),
		.token_valid   (token_valid),
		.token_is_copy (token_is_copy),
		.token_data    (token_data),
		.out_credit    (out_credit),
		.in_credit     (in_credit),
		.out_byte      (out_byte),
		.out_valid     (out_valid)
	);

	lz_checker checker_i (
		.clock         (clock),
		.reset         (reset),
		.token_valid   (token_valid),
		.token_is_copy (token_is_copy),
		.token_data    (token_data),
		.in_credit     (in_credit),
		.out_valid     (out_valid),
		.out_byte      (out_byte),
		.test_end      (test_end),
		.test_id       (test_id),
		.test_ack      (test_ack),
		.error_count   (error_count),
		.checked_count (checked_count)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		if (!reset && in_credit)
			credits_back++;
		if (!reset && out_valid)
			bytes_consumed++;
	end

	// sink gives back one credit per byte after a random pause
	initial begin
		int pause;
		out_credit = 1'b0;
		pause = 0;
		forever begin
			@(negedge clock);
			out_credit = 1'b0;
			if (credits_returned < bytes_consumed && pause == 0) begin
				out_credit = 1'b1;
				credits_returned++;
				pause = $random(seed) & 7;
			end else if (credits_returned < bytes_consumed)
				pause--;
		end
	end

	task automatic send_token(input stim_t entry, output logic ok);
		int waited;
		waited = 0;
		while (tokens_sent - credits_back >= `LZ_TOKEN_QUEUE_DEPTH && waited < credit_limit) begin
			@(negedge clock);
			waited++;
		end
		ok = tokens_sent - credits_back < `LZ_TOKEN_QUEUE_DEPTH;
		if (!ok)
			$display("no upstream credit came back, the token queue is stuck");
		else begin
			token_valid = 1'b1;
			token_is_copy = entry.is_copy;
			token_data = entry.data;
			tokens_sent++;
			@(negedge clock);
			token_valid = 1'b0;
		end
	endtask

	task automatic end_test(input logic [3:0] test, output logic ok);
		int waited;
		waited = 0;
		test_id = test;
		test_end = 1'b1;
		while (!test_ack && waited < drain_limit) begin
			@(negedge clock);
			waited++;
		end
		test_end = 1'b0;
		ok = test_ack;
		if (!test_ack)
			$display("checker never finished test %0d", test);
	endtask

	initial begin
		int tests_run;
		logic ok;
		tests_run = 0;
		ok = 1'b1;
		reset = 1'b1;
		token_valid = 1'b0;
		token_is_copy = 1'b0;
		token_data = '0;
		test_end = 1'b0;
		test_id = '0;
		repeat (5) @(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < stim_count && ok; i++) begin
			if (i > 0 && stim_table[i].test != stim_table[i - 1].test) begin
				end_test(stim_table[i - 1].test, ok);
				tests_run++;
			end
			if (ok)
				send_token(stim_table[i], ok);
		end
		if (ok) begin
			end_test(stim_table[stim_count - 1].test, ok);
			tests_run++;
		end
		$display("%0d tests, %0d bytes checked, %0d errors", tests_run, checked_count, error_count);
		if (ok && error_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
